// File: rv_ex.f
+incdir+.
rv_ex_pkg.sv
rv_alu.sv
rv_branch_unit.sv
rv_execute_stage.sv
rv_redirect_unit.sv
rv_ex_top.sv
tb_clk_gen.sv
tb_rv_ex_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       := tb_rv_ex_top
FILELIST  := rv_ex.f
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_rv_ex_top.sv
`timescale 1ns/1ps

`include "rv_ex_consts.svh"

module tb_rv_ex_top;

	localparam int RESET_CYCLES = 10;
	localparam int N_ALU        = 200;
	localparam int N_BR         = 200;
	localparam int N_CARRY      = 100;
	localparam int N_BURST      = 40;
	localparam int N_RDR        = 200;
	localparam int TOTAL_CYCLES = RESET_CYCLES + N_ALU + N_BR + N_CARRY + N_BURST * 7 + N_RDR;
	localparam int WATCHDOG_NS  = TOTAL_CYCLES * 8 * 2;

	typedef struct packed {
		logic [`RV_XLEN-1:0]      pc;
		rv_ex_pkg::exe_fun_e      fun;
		logic [`RV_XLEN-1:0]      op1;
		logic [`RV_XLEN-1:0]      op2;
		logic [`RV_XLEN-1:0]      rs2;
		logic [`RV_MEM_WEN_W-1:0] mem_wen;
		logic                     rf_wen;
		logic [`RV_WB_SEL_W-1:0]  wb_sel;
		logic [`RV_REG_AW-1:0]    wb_addr;
		logic [`RV_CSR_CMD_W-1:0] csr_cmd;
		logic                     jmp;
		logic [`RV_XLEN-1:0]      imm_i;
		logic [`RV_XLEN-1:0]      imm_b;
		logic                     ecall;
	} inst_t;

	logic clk, rst_n, stall, rf_wen, jmp_flg, inst_is_ecall, ex_rf_wen, redirect;
	logic [`RV_XLEN-1:0] pc, op1_data, op2_data, rs2_data, imm_i_sext, imm_b_sext, trap_vector;
	logic [`RV_XLEN-1:0] alu_out, ex_pc, ex_rs2_data, ex_op1_data, ex_imm_i, redirect_pc;
	logic [`RV_MEM_WEN_W-1:0] mem_wen, ex_mem_wen;
	logic [`RV_WB_SEL_W-1:0]  wb_sel, ex_wb_sel;
	logic [`RV_REG_AW-1:0]    wb_addr, ex_wb_addr;
	logic [`RV_CSR_CMD_W-1:0] csr_cmd, ex_csr_cmd;
	rv_ex_pkg::exe_fun_e      exe_fun;

	inst_t model_sel;  // Instruction the DUT executes this cycle.
	inst_t model_save;
	int    errors = 0;
	int    checks = 0;
	int    test_mark = 0;

	tb_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(RESET_CYCLES)) clk_gen_inst (
		.clk   (clk),
		.rst_n (rst_n)
	);

	rv_ex_top rv_ex_top_inst (.*);

	function automatic logic [`RV_XLEN-1:0] alu_model(input rv_ex_pkg::exe_fun_e f,
			input logic [31:0] a, input logic [31:0] b);
		logic [63:0] ext;
		ext = {{32{a[31]}}, a} >> b[4:0];
		case (f)
			rv_ex_pkg::ALU_ADD:   return a + b;
			rv_ex_pkg::ALU_SUB:   return a - b;
			rv_ex_pkg::ALU_AND:   return a & b;
			rv_ex_pkg::ALU_OR:    return a | b;
			rv_ex_pkg::ALU_XOR:   return a ^ b;
			rv_ex_pkg::ALU_SLL:   return a << b[4:0];
			rv_ex_pkg::ALU_SRL:   return a >> b[4:0];
			rv_ex_pkg::ALU_SRA:   return ext[31:0]; // Sign fill from the upper half.
			rv_ex_pkg::ALU_SLT:   return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
			rv_ex_pkg::ALU_SLTU:  return {31'b0, a < b};
			rv_ex_pkg::ALU_JALR:  return (a + b) & 32'hffff_fffe;
			rv_ex_pkg::ALU_COPY1: return a;
			default:              return 32'h0;
		endcase
	endfunction

	function automatic logic branch_model(input rv_ex_pkg::exe_fun_e f,
			input logic [31:0] a, input logic [31:0] b);
		logic lt;
		lt = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000); // Offset binary gives signed order.
		case (f)
			rv_ex_pkg::BR_BEQ:  return a == b;
			rv_ex_pkg::BR_BNE:  return a != b;
			rv_ex_pkg::BR_BLT:  return lt;
			rv_ex_pkg::BR_BGE:  return !lt;
			rv_ex_pkg::BR_BLTU: return a < b;
			rv_ex_pkg::BR_BGEU: return a >= b;
			default:            return 1'b0;
		endcase
	endfunction

	function automatic rv_ex_pkg::exe_fun_e pick_fun(input int unsigned base,
			input int unsigned count);
		logic [31:0] r;
		r = base + $urandom % count;
		return rv_ex_pkg::exe_fun_e'(r[4:0]);
	endfunction

	function automatic inst_t rand_inst(input rv_ex_pkg::exe_fun_e f, input logic flow);
		inst_t i;
		logic [31:0] r;
		r         = $urandom;
		i.pc      = $urandom & 32'hffff_fffc;
		i.fun     = f;
		i.op1     = $urandom;
		i.op2     = $urandom;
		i.rs2     = $urandom;
		i.mem_wen = r[4:0];
		i.rf_wen  = r[5];
		i.wb_sel  = r[9:6];
		i.wb_addr = r[14:10];
		i.csr_cmd = r[17:15];
		i.jmp     = flow & r[18];
		i.ecall   = flow & r[19] & r[20];
		i.imm_i   = $urandom;
		i.imm_b   = {{19{r[31]}}, r[30:19], 1'b0}; // B-type offset, even.
		return i;
	endfunction

	task automatic check_word(input string name, input logic [`RV_XLEN-1:0] got,
			input logic [`RV_XLEN-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_ctrl(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_fun(input string name, input rv_ex_pkg::exe_fun_e got,
			input rv_ex_pkg::exe_fun_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s got %s expected %s", $time, name,
				got.name(), exp.name());
		end
	endtask

	task automatic set_inputs(input inst_t i, input logic st);
		pc            = i.pc;
		exe_fun       = i.fun;
		op1_data      = i.op1;
		op2_data      = i.op2;
		rs2_data      = i.rs2;
		mem_wen       = i.mem_wen;
		rf_wen        = i.rf_wen;
		wb_sel        = i.wb_sel;
		wb_addr       = i.wb_addr;
		csr_cmd       = i.csr_cmd;
		jmp_flg       = i.jmp;
		imm_i_sext    = i.imm_i;
		imm_b_sext    = i.imm_b;
		inst_is_ecall = i.ecall;
		stall         = st;
	endtask

	task automatic check_outputs();
		logic [`RV_XLEN-1:0] exp_alu;
		logic [`RV_XLEN-1:0] exp_rpc;
		logic                exp_rdr;
		exp_alu = alu_model(model_sel.fun, model_sel.op1, model_sel.op2);
		exp_rdr = 1'b1;
		exp_rpc = '0;
		if (model_sel.ecall)
			exp_rpc = trap_vector;
		else if (branch_model(model_sel.fun, model_sel.op1, model_sel.op2))
			exp_rpc = model_sel.pc + model_sel.imm_b;
		else if (model_sel.jmp)
			exp_rpc = exp_alu;
		else
			exp_rdr = 1'b0;
		check_word("alu_out", alu_out, exp_alu);
		check_word("ex_pc", ex_pc, model_sel.pc);
		check_word("ex_rs2_data", ex_rs2_data, model_sel.rs2);
		check_word("ex_op1_data", ex_op1_data, model_sel.op1);
		check_word("ex_imm_i", ex_imm_i, model_sel.imm_i);
		check_ctrl("ex_mem_wen", 8'(ex_mem_wen), 8'(model_sel.mem_wen));
		check_ctrl("ex_rf_wen", 8'(ex_rf_wen), 8'(model_sel.rf_wen));
		check_ctrl("ex_wb_sel", 8'(ex_wb_sel), 8'(model_sel.wb_sel));
		check_ctrl("ex_wb_addr", 8'(ex_wb_addr), 8'(model_sel.wb_addr));
		check_ctrl("ex_csr_cmd", 8'(ex_csr_cmd), 8'(model_sel.csr_cmd));
		check_ctrl("redirect", 8'(redirect), 8'(exp_rdr));
		check_word("redirect_pc", redirect_pc, exp_rpc);
		check_fun("save_exe_fun", rv_ex_top_inst.execute_stage_inst.save_exe_fun, model_save.fun);
	endtask

	// Drive at edge plus 1 ns, then check after the next edge.
	task automatic step(input inst_t i, input logic st);
		set_inputs(i, st);
		model_sel  = st ? model_save : i;
		model_save = model_sel;
		@(posedge clk);
		#1;
		check_outputs();
	endtask

	task automatic end_test(input string name);
		$display("%s: finished, %0d errors", name, errors - test_mark);
		test_mark = errors;
	endtask

	initial begin
		inst_t       i;
		inst_t       busy;
		logic [31:0] s;
		logic [31:0] t;
		int unsigned len;
		s = $urandom(15324);
		i = '0;
		i.fun = rv_ex_pkg::EXE_NONE;
		model_sel  = i;
		model_save = i;
		busy     = '1; // Taken BEQ with every control set.
		busy.fun = rv_ex_pkg::BR_BEQ;
		set_inputs(busy, 1'b0);
		trap_vector = '0;

		for (int n = 0; n < RESET_CYCLES; n++) begin
			@(posedge clk);
			#1;
			check_ctrl("ex_rf_wen", 8'(ex_rf_wen), 8'h0);
			check_ctrl("ex_mem_wen", 8'(ex_mem_wen), 8'h0);
			check_ctrl("redirect", 8'(redirect), 8'h0);
			check_fun("save_exe_fun", rv_ex_top_inst.execute_stage_inst.save_exe_fun,
				rv_ex_pkg::EXE_NONE);
		end
		end_test("reset");

		for (int n = 0; n < N_ALU; n++)
			step(rand_inst(pick_fun(1, 12), 1'b0), 1'b0);
		end_test("alu");

		for (int n = 0; n < N_BR; n++) begin
			i = rand_inst(pick_fun(13, 6), 1'b0);
			s = $urandom;
			case (s[1:0])
				2'd1: i.op2 = i.op1;
				2'd2: begin
					i.op1 = 32'h8000_0000;
					i.op2 = 32'h7fff_ffff;
				end
				2'd3: begin
					i.op1 = 32'hffff_ffff;
					i.op2 = 32'h0000_0000;
				end
				default: ;
			endcase
			if (s[2]) begin
				t     = i.op1;
				i.op1 = i.op2;
				i.op2 = t;
			end
			step(i, 1'b0);
		end
		end_test("branch");

		for (int n = 0; n < N_CARRY; n++)
			step(rand_inst(pick_fun(0, 19), 1'b0), 1'b0);
		end_test("carried");

		for (int n = 0; n < N_BURST; n++) begin
			step(rand_inst(pick_fun(0, 19), 1'b1), 1'b0);
			s   = $urandom;
			len = 1 + s % 5;
			repeat (len) step(rand_inst(pick_fun(0, 19), 1'b1), 1'b1);
			step(rand_inst(pick_fun(0, 19), 1'b1), 1'b0);
		end
		end_test("stall");

		for (int n = 0; n < N_RDR; n++) begin
			trap_vector = $urandom & 32'hffff_fffc;
			step(rand_inst(pick_fun(0, 19), 1'b1), 1'b0);
		end
		end_test("redirect");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired: the tests did not finish in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Released just after the last reset edge.
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

// File: rv_ex_top.sv
`timescale 1ns/1ps

`include "rv_ex_consts.svh"

module rv_ex_top (
	input  logic                      clk,
	input  logic                      rst_n,

	input  logic [`RV_XLEN-1:0]       pc,
	input  rv_ex_pkg::exe_fun_e       exe_fun,
	input  logic [`RV_XLEN-1:0]       op1_data,
	input  logic [`RV_XLEN-1:0]       op2_data,
	input  logic [`RV_XLEN-1:0]       rs2_data,
	input  logic [`RV_MEM_WEN_W-1:0]  mem_wen,
	input  logic                      rf_wen,
	input  logic [`RV_WB_SEL_W-1:0]   wb_sel,
	input  logic [`RV_REG_AW-1:0]     wb_addr,
	input  logic [`RV_CSR_CMD_W-1:0]  csr_cmd,
	input  logic                      jmp_flg,
	input  logic [`RV_XLEN-1:0]       imm_i_sext,
	input  logic [`RV_XLEN-1:0]       imm_b_sext,
	input  logic                      inst_is_ecall,
	input  logic                      stall,
	input  logic [`RV_XLEN-1:0]       trap_vector,

	output logic [`RV_XLEN-1:0]       alu_out,
	output logic [`RV_XLEN-1:0]       ex_pc,
	output logic [`RV_MEM_WEN_W-1:0]  ex_mem_wen,
	output logic                      ex_rf_wen,
	output logic [`RV_XLEN-1:0]       ex_rs2_data,
	output logic [`RV_XLEN-1:0]       ex_op1_data,
	output logic [`RV_WB_SEL_W-1:0]   ex_wb_sel,
	output logic [`RV_REG_AW-1:0]     ex_wb_addr,
	output logic [`RV_CSR_CMD_W-1:0]  ex_csr_cmd,
	output logic [`RV_XLEN-1:0]       ex_imm_i,

	output logic                      redirect,
	output logic [`RV_XLEN-1:0]       redirect_pc
);

	// Registered outcomes that only feed the redirect.
	logic                 br_flg;
	logic [`RV_XLEN-1:0]  br_target;
	logic                 ex_jmp_flg;
	logic                 ex_inst_is_ecall;

	rv_execute_stage execute_stage_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.stall            (stall),
		.pc               (pc),
		.exe_fun          (exe_fun),
		.op1_data         (op1_data),
		.op2_data         (op2_data),
		.rs2_data         (rs2_data),
		.mem_wen          (mem_wen),
		.rf_wen           (rf_wen),
		.wb_sel           (wb_sel),
		.wb_addr          (wb_addr),
		.csr_cmd          (csr_cmd),
		.jmp_flg          (jmp_flg),
		.imm_i_sext       (imm_i_sext),
		.imm_b_sext       (imm_b_sext),
		.inst_is_ecall    (inst_is_ecall),
		.alu_out          (alu_out),
		.br_flg           (br_flg),
		.br_target        (br_target),
		.ex_pc            (ex_pc),
		.ex_mem_wen       (ex_mem_wen),
		.ex_rf_wen        (ex_rf_wen),
		.ex_rs2_data      (ex_rs2_data),
		.ex_op1_data      (ex_op1_data),
		.ex_wb_sel        (ex_wb_sel),
		.ex_wb_addr       (ex_wb_addr),
		.ex_csr_cmd       (ex_csr_cmd),
		.ex_jmp_flg       (ex_jmp_flg),
		.ex_imm_i         (ex_imm_i),
		.ex_inst_is_ecall (ex_inst_is_ecall)
	);

	rv_redirect_unit redirect_unit_inst (
		.br_flg        (br_flg),
		.jmp_flg       (ex_jmp_flg),
		.inst_is_ecall (ex_inst_is_ecall),
		.br_target     (br_target),
		.alu_out       (alu_out),
		.trap_vector   (trap_vector),
		.redirect      (redirect),
		.redirect_pc   (redirect_pc)
	);

endmodule

// File: rv_redirect_unit.sv
`timescale 1ns/1ps

`include "rv_ex_consts.svh"

module rv_redirect_unit (
	input  logic                 br_flg,
	input  logic                 jmp_flg,
	input  logic                 inst_is_ecall,
	input  logic [`RV_XLEN-1:0]  br_target,
	input  logic [`RV_XLEN-1:0]  alu_out,
	input  logic [`RV_XLEN-1:0]  trap_vector,
	output logic                 redirect,
	output logic [`RV_XLEN-1:0]  redirect_pc
);

	always_comb begin
		redirect    = 1'b1;
		redirect_pc = '0;
		if (inst_is_ecall) begin
			redirect_pc = trap_vector; // Trap wins over everything.
		end else if (br_flg) begin
			redirect_pc = br_target;
		end else if (jmp_flg) begin
			redirect_pc = alu_out; // Jump target from the ALU.
		end else begin
			redirect = 1'b0;
		end
	end

endmodule

// File: rv_execute_stage.sv
`timescale 1ns/1ps

`include "rv_ex_consts.svh"

module rv_execute_stage (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      stall,

	input  logic [`RV_XLEN-1:0]       pc,
	input  rv_ex_pkg::exe_fun_e       exe_fun,
	input  logic [`RV_XLEN-1:0]       op1_data,
	input  logic [`RV_XLEN-1:0]       op2_data,
	input  logic [`RV_XLEN-1:0]       rs2_data,
	input  logic [`RV_MEM_WEN_W-1:0]  mem_wen,
	input  logic                      rf_wen,
	input  logic [`RV_WB_SEL_W-1:0]   wb_sel,
	input  logic [`RV_REG_AW-1:0]     wb_addr,
	input  logic [`RV_CSR_CMD_W-1:0]  csr_cmd,
	input  logic                      jmp_flg,
	input  logic [`RV_XLEN-1:0]       imm_i_sext,
	input  logic [`RV_XLEN-1:0]       imm_b_sext,
	input  logic                      inst_is_ecall,

	output logic [`RV_XLEN-1:0]       alu_out,
	output logic                      br_flg,
	output logic [`RV_XLEN-1:0]       br_target,
	output logic [`RV_XLEN-1:0]       ex_pc,
	output logic [`RV_MEM_WEN_W-1:0]  ex_mem_wen,
	output logic                      ex_rf_wen,
	output logic [`RV_XLEN-1:0]       ex_rs2_data,
	output logic [`RV_XLEN-1:0]       ex_op1_data,
	output logic [`RV_WB_SEL_W-1:0]   ex_wb_sel,
	output logic [`RV_REG_AW-1:0]     ex_wb_addr,
	output logic [`RV_CSR_CMD_W-1:0]  ex_csr_cmd,
	output logic                      ex_jmp_flg,
	output logic [`RV_XLEN-1:0]       ex_imm_i,
	output logic                      ex_inst_is_ecall
);

	// Copy of the last instruction executed.
	logic [`RV_XLEN-1:0]       save_pc;
	rv_ex_pkg::exe_fun_e       save_exe_fun;
	logic [`RV_XLEN-1:0]       save_op1_data;
	logic [`RV_XLEN-1:0]       save_op2_data;
	logic [`RV_XLEN-1:0]       save_rs2_data;
	logic [`RV_MEM_WEN_W-1:0]  save_mem_wen;
	logic                      save_rf_wen;
	logic [`RV_WB_SEL_W-1:0]   save_wb_sel;
	logic [`RV_REG_AW-1:0]     save_wb_addr;
	logic [`RV_CSR_CMD_W-1:0]  save_csr_cmd;
	logic                      save_jmp_flg;
	logic [`RV_XLEN-1:0]       save_imm_i_sext;
	logic [`RV_XLEN-1:0]       save_imm_b_sext;
	logic                      save_inst_is_ecall;

	// Operands actually executed this cycle.
	logic [`RV_XLEN-1:0]       sel_pc;
	rv_ex_pkg::exe_fun_e       sel_exe_fun;
	logic [`RV_XLEN-1:0]       sel_op1_data;
	logic [`RV_XLEN-1:0]       sel_op2_data;
	logic [`RV_XLEN-1:0]       sel_rs2_data;
	logic [`RV_MEM_WEN_W-1:0]  sel_mem_wen;
	logic                      sel_rf_wen;
	logic [`RV_WB_SEL_W-1:0]   sel_wb_sel;
	logic [`RV_REG_AW-1:0]     sel_wb_addr;
	logic [`RV_CSR_CMD_W-1:0]  sel_csr_cmd;
	logic                      sel_jmp_flg;
	logic [`RV_XLEN-1:0]       sel_imm_i_sext;
	logic [`RV_XLEN-1:0]       sel_imm_b_sext;
	logic                      sel_inst_is_ecall;

	logic [`RV_XLEN-1:0]       alu_result;
	logic                      br_taken;
	logic [`RV_XLEN-1:0]       br_addr;

	// Stall replays the saved instruction.
	assign sel_pc            = stall ? save_pc            : pc;
	assign sel_exe_fun       = stall ? save_exe_fun       : exe_fun;
	assign sel_op1_data      = stall ? save_op1_data      : op1_data;
	assign sel_op2_data      = stall ? save_op2_data      : op2_data;
	assign sel_rs2_data      = stall ? save_rs2_data      : rs2_data;
	assign sel_mem_wen       = stall ? save_mem_wen       : mem_wen;
	assign sel_rf_wen        = stall ? save_rf_wen        : rf_wen;
	assign sel_wb_sel        = stall ? save_wb_sel        : wb_sel;
	assign sel_wb_addr       = stall ? save_wb_addr       : wb_addr;
	assign sel_csr_cmd       = stall ? save_csr_cmd       : csr_cmd;
	assign sel_jmp_flg       = stall ? save_jmp_flg       : jmp_flg;
	assign sel_imm_i_sext    = stall ? save_imm_i_sext    : imm_i_sext;
	assign sel_imm_b_sext    = stall ? save_imm_b_sext    : imm_b_sext;
	assign sel_inst_is_ecall = stall ? save_inst_is_ecall : inst_is_ecall;

	rv_alu alu_inst (
		.exe_fun (sel_exe_fun),
		.op1     (sel_op1_data),
		.op2     (sel_op2_data),
		.result  (alu_result)
	);

	rv_branch_unit branch_unit_inst (
		.exe_fun (sel_exe_fun),
		.op1     (sel_op1_data),
		.op2     (sel_op2_data),
		.pc      (sel_pc),
		.imm_b   (sel_imm_b_sext),
		.taken   (br_taken),
		.target  (br_addr)
	);

	// A stall right after reset replays a NONE instruction.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			save_pc            <= '0;
			save_exe_fun       <= rv_ex_pkg::EXE_NONE;
			save_op1_data      <= '0;
			save_op2_data      <= '0;
			save_rs2_data      <= '0;
			save_mem_wen       <= '0;
			save_rf_wen        <= 1'b0;
			save_wb_sel        <= '0;
			save_wb_addr       <= '0;
			save_csr_cmd       <= '0;
			save_jmp_flg       <= 1'b0;
			save_imm_i_sext    <= '0;
			save_imm_b_sext    <= '0;
			save_inst_is_ecall <= 1'b0;
		end else begin
			save_pc            <= sel_pc;
			save_exe_fun       <= sel_exe_fun;
			save_op1_data      <= sel_op1_data;
			save_op2_data      <= sel_op2_data;
			save_rs2_data      <= sel_rs2_data;
			save_mem_wen       <= sel_mem_wen;
			save_rf_wen        <= sel_rf_wen;
			save_wb_sel        <= sel_wb_sel;
			save_wb_addr       <= sel_wb_addr;
			save_csr_cmd       <= sel_csr_cmd;
			save_jmp_flg       <= sel_jmp_flg;
			save_imm_i_sext    <= sel_imm_i_sext;
			save_imm_b_sext    <= sel_imm_b_sext;
			save_inst_is_ecall <= sel_inst_is_ecall;
		end
	end

	// EX/MEM control bits.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem_wen       <= '0;
			ex_rf_wen        <= 1'b0;
			ex_jmp_flg       <= 1'b0;
			ex_inst_is_ecall <= 1'b0;
			br_flg           <= 1'b0;
		end else begin
			ex_mem_wen       <= sel_mem_wen;
			ex_rf_wen        <= sel_rf_wen;
			ex_jmp_flg       <= sel_jmp_flg;
			ex_inst_is_ecall <= sel_inst_is_ecall;
			br_flg           <= br_taken;
		end
	end

	// EX/MEM payload.
	always_ff @(posedge clk) begin
		alu_out     <= alu_result;
		br_target   <= br_addr;
		ex_pc       <= sel_pc;
		ex_rs2_data <= sel_rs2_data; // Store data.
		ex_op1_data <= sel_op1_data; // CSR source.
		ex_wb_sel   <= sel_wb_sel;
		ex_wb_addr  <= sel_wb_addr;
		ex_csr_cmd  <= sel_csr_cmd;
		ex_imm_i    <= sel_imm_i_sext;
	end

endmodule

// File: rv_branch_unit.sv
`timescale 1ns/1ps

`include "rv_ex_consts.svh"

module rv_branch_unit (
	input  rv_ex_pkg::exe_fun_e  exe_fun,
	input  logic [`RV_XLEN-1:0]  op1,
	input  logic [`RV_XLEN-1:0]  op2,
	input  logic [`RV_XLEN-1:0]  pc,
	input  logic [`RV_XLEN-1:0]  imm_b,
	output logic                 taken,
	output logic [`RV_XLEN-1:0]  target
);

	logic eq;
	logic lt_s;
	logic lt_u;

	assign eq   = (op1 == op2);
	assign lt_s = ($signed(op1) < $signed(op2));
	assign lt_u = (op1 < op2);

	always_comb begin
		case (exe_fun)
			rv_ex_pkg::BR_BEQ:  taken = eq;
			rv_ex_pkg::BR_BNE:  taken = !eq;
			rv_ex_pkg::BR_BLT:  taken = lt_s;
			rv_ex_pkg::BR_BGE:  taken = !lt_s;
			rv_ex_pkg::BR_BLTU: taken = lt_u;
			rv_ex_pkg::BR_BGEU: taken = !lt_u;
			default:            taken = 1'b0; // Not a branch.
		endcase
	end

	// Computed for every instruction, only used when taken.
	assign target = pc + imm_b;

endmodule

// File: rv_alu.sv
`timescale 1ns/1ps

`include "rv_ex_consts.svh"

module rv_alu (
	input  rv_ex_pkg::exe_fun_e  exe_fun,
	input  logic [`RV_XLEN-1:0]  op1,
	input  logic [`RV_XLEN-1:0]  op2,
	output logic [`RV_XLEN-1:0]  result
);

	logic [4:0]          shamt;
	logic [`RV_XLEN-1:0] sum;

	assign shamt = op2[4:0];
	assign sum   = op1 + op2; // Shared by ADD and JALR.

	always_comb begin
		case (exe_fun)
			rv_ex_pkg::ALU_ADD:   result = sum;
			rv_ex_pkg::ALU_SUB:   result = op1 - op2;
			rv_ex_pkg::ALU_AND:   result = op1 & op2;
			rv_ex_pkg::ALU_OR:    result = op1 | op2;
			rv_ex_pkg::ALU_XOR:   result = op1 ^ op2;
			rv_ex_pkg::ALU_SLL:   result = op1 << shamt;
			rv_ex_pkg::ALU_SRL:   result = op1 >> shamt;
			rv_ex_pkg::ALU_SRA:   result = $unsigned($signed(op1) >>> shamt);
			rv_ex_pkg::ALU_SLT: begin
				result = {{(`RV_XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
			end
			rv_ex_pkg::ALU_SLTU: begin
				result = {{(`RV_XLEN-1){1'b0}}, op1 < op2};
			end
			rv_ex_pkg::ALU_JALR:  result = {sum[`RV_XLEN-1:1], 1'b0}; // Target is halfword aligned.
			rv_ex_pkg::ALU_COPY1: result = op1;
			default:              result = '0;
		endcase
	end

endmodule

// File: rv_ex_pkg.sv
package rv_ex_pkg;

	// Execute function code, as produced by decode.
	typedef enum logic [4:0] {
		EXE_NONE  = 5'd0,

		// ALU operations.
		ALU_ADD   = 5'd1,
		ALU_SUB   = 5'd2,
		ALU_AND   = 5'd3,
		ALU_OR    = 5'd4,
		ALU_XOR   = 5'd5,
		ALU_SLL   = 5'd6,
		ALU_SRL   = 5'd7,
		ALU_SRA   = 5'd8,
		ALU_SLT   = 5'd9,
		ALU_SLTU  = 5'd10,
		ALU_JALR  = 5'd11,
		ALU_COPY1 = 5'd12,

		// Conditional branches.
		BR_BEQ    = 5'd13,
		BR_BNE    = 5'd14,
		BR_BLT    = 5'd15,
		BR_BGE    = 5'd16,
		BR_BLTU   = 5'd17,
		BR_BGEU   = 5'd18
	} exe_fun_e;

endpackage

// File: rv_ex_consts.svh
`ifndef RV_EX_CONSTS_SVH
`define RV_EX_CONSTS_SVH

// Data word width.
`define RV_XLEN 32

// Register file address width.
`define RV_REG_AW 5

// Write-back and CSR control widths.
`define RV_WB_SEL_W 4
`define RV_CSR_CMD_W 3

// Memory write-enable code width.
`define RV_MEM_WEN_W 5

// mcause value for an environment call from M-mode.
`define RV_TRAP_CAUSE_ECALL 32'd11

`endif
